// File: rtl/msg_mon_pkg.sv
// ==================================================
// Shared widths, APB register offsets and the strap
// encoding of the debug-pad and message monitor
// ==================================================

package msg_mon_pkg;

  // RAM side of the snoop path
  typedef logic [31:0] ram_addr_t;
  typedef logic [31:0] ram_data_t;

  // APB register port
  typedef logic [7:0] apb_addr_t;

  // Pad function chosen by the strap pin, high selects JTAG
  typedef enum logic {
    STRAP_SPI  = 1'b0,
    STRAP_JTAG = 1'b1
  } strap_sel_e;

  // Register map
  localparam apb_addr_t REG_MSG_ADDR = 8'h00;
  localparam apb_addr_t REG_STATUS   = 8'h04;
  localparam apb_addr_t REG_DATA     = 8'h08;

  // STATUS fields
  localparam int STATUS_OVF_BIT   = 8;
  localparam int STATUS_STRAP_BIT = 9;

endpackage

// File: rtl/ram_snoop_if.sv
// ==================================================
// Snooped RAM write bus between the snoop stage and
// the message FIFO
// ==================================================

`timescale 1ns/10ps

interface ram_snoop_if;

  logic                  req;
  logic                  write;
  msg_mon_pkg::ram_addr_t addr;
  msg_mon_pkg::ram_data_t wdata;
  // Registered match against the message address
  logic                  hit;

  modport source (
    output req,
    output write,
    output addr,
    output wdata,
    output hit
  );

  modport sink (
    input req,
    input write,
    input addr,
    input wdata,
    input hit
  );

endinterface

// File: rtl/pad_strap_mux.sv
// ==================================================
// One-shot strap sampling and JTAG/SPI steering of
// the shared debug pads
// ==================================================

`timescale 1ns/10ps

module pad_strap_mux (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    strap_jtag_spi_n_i,
  input  logic                    jtag_tck_i,
  input  logic                    jtag_tms_i,
  input  logic                    jtag_tdi_i,
  input  logic                    spi_sck_i,
  input  logic                    spi_csb_i,
  input  logic                    spi_mosi_i,
  input  logic                    pad_tdo_miso_i,
  output logic                    pad_clk_o,
  output logic                    pad_din_o,
  output logic                    pad_sel_o,
  output logic                    jtag_tdo_o,
  output logic                    spi_miso_o,
  output msg_mon_pkg::strap_sel_e strap_o
);

  msg_mon_pkg::strap_sel_e strap_q;
  logic                    sampled_q;
  logic                    jtag_sel;

  // Strap is taken once, on the first edge out of reset, then frozen
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      strap_q   <= msg_mon_pkg::STRAP_SPI;
      sampled_q <= 1'b0;
    end else if (!sampled_q) begin
      strap_q   <= msg_mon_pkg::strap_sel_e'(strap_jtag_spi_n_i);
      sampled_q <= 1'b1;
    end
  end

  assign jtag_sel = (strap_q == msg_mon_pkg::STRAP_JTAG);
  assign strap_o  = strap_q;

  // Outbound pads
  assign pad_clk_o = jtag_sel ? jtag_tck_i : spi_sck_i;
  assign pad_din_o = jtag_sel ? jtag_tdi_i : spi_mosi_i;
  assign pad_sel_o = jtag_sel ? jtag_tms_i : spi_csb_i;

  // Return pad goes to the active function only, the other one sees 0
  assign jtag_tdo_o = jtag_sel ? pad_tdo_miso_i : 1'b0;
  assign spi_miso_o = jtag_sel ? 1'b0 : pad_tdo_miso_i;

endmodule

// File: rtl/write_snoop.sv
// ==================================================
// Snoop stage, registers RAM write requests and flags
// writes to the software message address
// ==================================================

`timescale 1ns/10ps

module write_snoop (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   ram_req_i,
  input  logic                   ram_write_i,
  input  msg_mon_pkg::ram_addr_t ram_addr_i,
  input  msg_mon_pkg::ram_data_t ram_wdata_i,
  input  msg_mon_pkg::ram_addr_t msg_addr_i,
  ram_snoop_if.source            snoop_o
);

  logic                   req_q;
  logic                   write_q;
  logic                   hit_q;
  msg_mon_pkg::ram_addr_t addr_q;
  msg_mon_pkg::ram_data_t wdata_q;
  logic                   hit_d;

  // Only a real write request to the message address counts
  assign hit_d = ram_req_i && ram_write_i && (ram_addr_i == msg_addr_i);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_q   <= 1'b0;
      write_q <= 1'b0;
      hit_q   <= 1'b0;
    end else begin
      req_q   <= ram_req_i;
      write_q <= ram_write_i;
      hit_q   <= hit_d;
    end
  end

  // Payload follows the request without reset
  always_ff @(posedge clk_i) begin
    addr_q  <= ram_addr_i;
    wdata_q <= ram_wdata_i;
  end

  assign snoop_o.req   = req_q;
  assign snoop_o.write = write_q;
  assign snoop_o.addr  = addr_q;
  assign snoop_o.wdata = wdata_q;
  assign snoop_o.hit   = hit_q;

endmodule

// File: rtl/msg_fifo.sv
// ==================================================
// Message FIFO stage with sticky overflow flag
// ==================================================

`timescale 1ns/10ps

module msg_fifo #(
  // Power of two, 2 to 128
  parameter int FIFO_DEPTH = 8
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  ram_snoop_if.sink              snoop_i,
  input  logic                   pop_i,
  output msg_mon_pkg::ram_data_t data_o,
  output logic [7:0]             count_o,
  output logic                   overflow_o,
  input  logic                   overflow_clr_i
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  msg_mon_pkg::ram_data_t mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0]       head_q;
  logic [PTR_W-1:0]       tail_q;
  logic [7:0]             count_q;
  logic                   overflow_q;
  logic                   empty;
  logic                   full;
  logic                   pop_ok;
  logic                   push_ok;

  assign empty  = (count_q == 8'd0);
  assign full   = (count_q == 8'(FIFO_DEPTH));
  assign pop_ok = pop_i && !empty;
  // A full FIFO still takes a word when one leaves in the same cycle
  assign push_ok = snoop_i.hit && (!full || pop_ok);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      head_q     <= '0;
      tail_q     <= '0;
      count_q    <= 8'd0;
      overflow_q <= 1'b0;
    end else begin
      if (push_ok) begin
        tail_q <= tail_q + 1'b1;
      end
      if (pop_ok) begin
        head_q <= head_q + 1'b1;
      end
      if (push_ok && !pop_ok) begin
        count_q <= count_q + 8'd1;
      end else if (pop_ok && !push_ok) begin
        count_q <= count_q - 8'd1;
      end
      // A new drop wins over a clear in the same cycle
      if (snoop_i.hit && !push_ok) begin
        overflow_q <= 1'b1;
      end else if (overflow_clr_i) begin
        overflow_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[tail_q] <= snoop_i.wdata;
    end
  end

  assign data_o     = mem_q[head_q];
  assign count_o    = count_q;
  assign overflow_o = overflow_q;

endmodule

// File: rtl/msg_apb_regs.sv
// ==================================================
// APB registers: message address, status, FIFO pop
// and strap readback
// ==================================================

`timescale 1ns/10ps

module msg_apb_regs (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  msg_mon_pkg::apb_addr_t  paddr_i,
  input  logic [31:0]             pwdata_i,
  output logic [31:0]             prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o,
  output msg_mon_pkg::ram_addr_t  msg_addr_o,
  output logic                    pop_o,
  output logic                    overflow_clr_o,
  input  msg_mon_pkg::ram_data_t  fifo_data_i,
  input  logic [7:0]              count_i,
  input  logic                    overflow_i,
  input  msg_mon_pkg::strap_sel_e strap_i
);

  msg_mon_pkg::ram_addr_t msg_addr_q;
  logic [31:0]            prdata_q;
  logic                   pslverr_q;
  logic                   pop_arm_q;
  logic                   setup;
  logic                   access;
  logic                   sel_addr;
  logic                   sel_status;
  logic                   sel_data;
  logic                   mapped;
  logic [31:0]            status;
  logic [31:0]            rdata;

  assign setup  = psel_i && !penable_i;
  assign access = psel_i && penable_i;

  assign sel_addr   = (paddr_i == msg_mon_pkg::REG_MSG_ADDR);
  assign sel_status = (paddr_i == msg_mon_pkg::REG_STATUS);
  assign sel_data   = (paddr_i == msg_mon_pkg::REG_DATA);
  assign mapped     = sel_addr || sel_status || sel_data;

  always_comb begin
    status                               = 32'd0;
    status[7:0]                          = count_i;
    status[msg_mon_pkg::STATUS_OVF_BIT]   = overflow_i;
    status[msg_mon_pkg::STATUS_STRAP_BIT] = (strap_i == msg_mon_pkg::STRAP_JTAG);
  end

  // Empty FIFO reads back as zero
  always_comb begin
    rdata = 32'd0;
    if (sel_addr) begin
      rdata = msg_addr_q;
    end else if (sel_status) begin
      rdata = status;
    end else if (sel_data && count_i != 8'd0) begin
      rdata = fifo_data_i;
    end
  end

  // Read data and error are prepared in setup so the access phase needs no wait
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prdata_q   <= 32'd0;
      pslverr_q  <= 1'b0;
      pop_arm_q  <= 1'b0;
      msg_addr_q <= '0;
    end else begin
      if (setup) begin
        prdata_q  <= pwrite_i ? 32'd0 : rdata;
        pslverr_q <= !mapped;
        // Pop only the word that was returned
        pop_arm_q <= !pwrite_i && sel_data && (count_i != 8'd0);
      end else if (access) begin
        pslverr_q <= 1'b0;
        pop_arm_q <= 1'b0;
      end
      if (access && pwrite_i && sel_addr) begin
        msg_addr_q <= pwdata_i;
      end
    end
  end

  assign pready_o       = access;
  assign prdata_o       = prdata_q;
  assign pslverr_o      = pslverr_q;
  assign msg_addr_o     = msg_addr_q;
  assign pop_o          = access && !pwrite_i && sel_data && pop_arm_q;
  // W1C on the overflow bit
  assign overflow_clr_o = access && pwrite_i && sel_status &&
                          pwdata_i[msg_mon_pkg::STATUS_OVF_BIT];

endmodule

// File: rtl/msg_mon_top.sv
// ==================================================
// Debug pad mux and software message monitor top
// ==================================================

`timescale 1ns/10ps

module msg_mon_top #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   strap_jtag_spi_n_i,
  input  logic                   jtag_tck_i,
  input  logic                   jtag_tms_i,
  input  logic                   jtag_tdi_i,
  input  logic                   spi_sck_i,
  input  logic                   spi_csb_i,
  input  logic                   spi_mosi_i,
  input  logic                   pad_tdo_miso_i,
  output logic                   pad_clk_o,
  output logic                   pad_din_o,
  output logic                   pad_sel_o,
  output logic                   jtag_tdo_o,
  output logic                   spi_miso_o,
  input  logic                   ram_req_i,
  input  logic                   ram_write_i,
  input  msg_mon_pkg::ram_addr_t ram_addr_i,
  input  msg_mon_pkg::ram_data_t ram_wdata_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  msg_mon_pkg::apb_addr_t paddr_i,
  input  logic [31:0]            pwdata_i,
  output logic [31:0]            prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o
);

  msg_mon_pkg::strap_sel_e strap;
  msg_mon_pkg::ram_addr_t  msg_addr;
  msg_mon_pkg::ram_data_t  fifo_data;
  logic [7:0]              fifo_count;
  logic                    fifo_overflow;
  logic                    fifo_pop;
  logic                    overflow_clr;

  ram_snoop_if snoop_bus ();

  pad_strap_mux u_pad_mux (
    .clk_i              (clk_i),
    .arst_n_i           (arst_n_i),
    .strap_jtag_spi_n_i (strap_jtag_spi_n_i),
    .jtag_tck_i         (jtag_tck_i),
    .jtag_tms_i         (jtag_tms_i),
    .jtag_tdi_i         (jtag_tdi_i),
    .spi_sck_i          (spi_sck_i),
    .spi_csb_i          (spi_csb_i),
    .spi_mosi_i         (spi_mosi_i),
    .pad_tdo_miso_i     (pad_tdo_miso_i),
    .pad_clk_o          (pad_clk_o),
    .pad_din_o          (pad_din_o),
    .pad_sel_o          (pad_sel_o),
    .jtag_tdo_o         (jtag_tdo_o),
    .spi_miso_o         (spi_miso_o),
    .strap_o            (strap)
  );

  // Stage 1
  write_snoop u_snoop (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .ram_req_i   (ram_req_i),
    .ram_write_i (ram_write_i),
    .ram_addr_i  (ram_addr_i),
    .ram_wdata_i (ram_wdata_i),
    .msg_addr_i  (msg_addr),
    .snoop_o     (snoop_bus.source)
  );

  // Stage 2
  msg_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .snoop_i        (snoop_bus.sink),
    .pop_i          (fifo_pop),
    .data_o         (fifo_data),
    .count_o        (fifo_count),
    .overflow_o     (fifo_overflow),
    .overflow_clr_i (overflow_clr)
  );

  msg_apb_regs u_regs (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .paddr_i        (paddr_i),
    .pwdata_i       (pwdata_i),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o),
    .msg_addr_o     (msg_addr),
    .pop_o          (fifo_pop),
    .overflow_clr_o (overflow_clr),
    .fifo_data_i    (fifo_data),
    .count_i        (fifo_count),
    .overflow_i     (fifo_overflow),
    .strap_i        (strap)
  );

endmodule

// File: tests/msg_mon_props.sv
// ==================================================
// Bound checks for the message monitor, with a cycle
// model of the snoop pipeline, FIFO and registers
// ==================================================

`timescale 1ns/10ps

module msg_mon_props #(
  parameter int FIFO_DEPTH = 8
) (
  input logic                   clk_i,
  input logic                   arst_n_i,
  input logic                   strap_jtag_spi_n_i,
  input logic                   jtag_tck_i,
  input logic                   jtag_tms_i,
  input logic                   jtag_tdi_i,
  input logic                   spi_sck_i,
  input logic                   spi_csb_i,
  input logic                   spi_mosi_i,
  input logic                   pad_tdo_miso_i,
  input logic                   pad_clk_o,
  input logic                   pad_din_o,
  input logic                   pad_sel_o,
  input logic                   jtag_tdo_o,
  input logic                   spi_miso_o,
  input logic                   ram_req_i,
  input logic                   ram_write_i,
  input msg_mon_pkg::ram_addr_t ram_addr_i,
  input msg_mon_pkg::ram_data_t ram_wdata_i,
  input logic                   psel_i,
  input logic                   penable_i,
  input logic                   pwrite_i,
  input msg_mon_pkg::apb_addr_t paddr_i,
  input logic [31:0]            pwdata_i,
  input logic [31:0]            prdata_o,
  input logic                   pready_o,
  input logic                   pslverr_o,
  input logic [7:0]             fifo_count
);

  msg_mon_pkg::ram_data_t shadow_q [$];
  msg_mon_pkg::ram_addr_t model_addr;
  msg_mon_pkg::ram_data_t s1_data;
  logic                   s1_hit;
  logic                   model_ovf;
  logic                   model_jtag;
  logic                   strap_done;
  logic                   pop_armed;
  logic [31:0]            exp_rdata;
  int                     exp_count;
  int                     fail_count = 0;
  logic                   setup;
  logic                   access;
  logic                   mapped;
  logic                   do_pop;

  assign setup  = psel_i && !penable_i;
  assign access = psel_i && penable_i;
  assign mapped = (paddr_i == msg_mon_pkg::REG_MSG_ADDR) ||
                  (paddr_i == msg_mon_pkg::REG_STATUS) ||
                  (paddr_i == msg_mon_pkg::REG_DATA);
  assign do_pop = access && !pwrite_i && (paddr_i == msg_mon_pkg::REG_DATA) && pop_armed;

  // Reference model, one snoop stage in front of a FIFO of FIFO_DEPTH words
  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      shadow_q.delete();
      model_addr <= '0;
      s1_data    <= '0;
      s1_hit     <= 1'b0;
      model_ovf  <= 1'b0;
      model_jtag <= 1'b0;
      strap_done <= 1'b0;
      pop_armed  <= 1'b0;
      exp_rdata  <= 32'd0;
      exp_count  <= 0;
    end else begin
      if (setup && !pwrite_i) begin
        pop_armed <= (paddr_i == msg_mon_pkg::REG_DATA) && (shadow_q.size() != 0);
        case (paddr_i)
          msg_mon_pkg::REG_MSG_ADDR: exp_rdata <= model_addr;
          msg_mon_pkg::REG_STATUS:
            exp_rdata <= {22'd0, model_jtag, model_ovf, 8'(shadow_q.size())};
          msg_mon_pkg::REG_DATA:
            exp_rdata <= (shadow_q.size() != 0) ? shadow_q[0] : 32'd0;
          default: exp_rdata <= 32'd0;
        endcase
      end else if (access) begin
        pop_armed <= 1'b0;
      end
      if (do_pop) begin
        void'(shadow_q.pop_front());
      end
      // Drop on full beats a clear in the same cycle
      if (s1_hit && shadow_q.size() >= FIFO_DEPTH) begin
        model_ovf <= 1'b1;
      end else if (access && pwrite_i && (paddr_i == msg_mon_pkg::REG_STATUS) &&
                   pwdata_i[8]) begin
        model_ovf <= 1'b0;
      end
      if (s1_hit && shadow_q.size() < FIFO_DEPTH) begin
        shadow_q.push_back(s1_data);
      end
      exp_count <= shadow_q.size();
      s1_hit    <= ram_req_i && ram_write_i && (ram_addr_i == model_addr);
      s1_data   <= ram_wdata_i;
      if (access && pwrite_i && (paddr_i == msg_mon_pkg::REG_MSG_ADDR)) begin
        model_addr <= pwdata_i;
      end
      if (!strap_done) begin
        model_jtag <= strap_jtag_spi_n_i;
        strap_done <= 1'b1;
      end
    end
  end

  a_reset_outputs: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> (prdata_o == 32'd0) && !pslverr_o)
  else begin
    $error("error %0t: prdata or pslverr not zero after reset", $time);
    fail_count++;
  end

  a_fifo_count: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    fifo_count == 8'(exp_count))
  else begin
    $error("error %0t: FIFO count %0d, expected %0d", $time, $sampled(fifo_count),
           $sampled(exp_count));
    fail_count++;
  end

  a_read_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (access && !pwrite_i) |-> prdata_o == exp_rdata)
  else begin
    $error("error %0t: read of 0x%02h gave 0x%08h, expected 0x%08h", $time,
           $sampled(paddr_i), $sampled(prdata_o), $sampled(exp_rdata));
    fail_count++;
  end

  a_pready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    access |-> pready_o)
  else begin
    $error("error %0t: pready low in access phase", $time);
    fail_count++;
  end

  a_pslverr: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    access |-> pslverr_o == !mapped)
  else begin
    $error("error %0t: pslverr wrong for offset 0x%02h", $time, $sampled(paddr_i));
    fail_count++;
  end

  a_pads_jtag: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    model_jtag |-> (pad_clk_o == jtag_tck_i) && (pad_din_o == jtag_tdi_i) &&
                   (pad_sel_o == jtag_tms_i) && (jtag_tdo_o == pad_tdo_miso_i) &&
                   !spi_miso_o)
  else begin
    $error("error %0t: pads do not follow JTAG", $time);
    fail_count++;
  end

  a_pads_spi: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !model_jtag |-> (pad_clk_o == spi_sck_i) && (pad_din_o == spi_mosi_i) &&
                    (pad_sel_o == spi_csb_i) && (spi_miso_o == pad_tdo_miso_i) &&
                    !jtag_tdo_o)
  else begin
    $error("error %0t: pads do not follow SPI", $time);
    fail_count++;
  end

endmodule

bind msg_mon_top msg_mon_props #(.FIFO_DEPTH(FIFO_DEPTH)) u_props (.*);

// File: tests/tb.sv
// ==================================================
// Testbench for the message monitor with clock, reset,
// APB and RAM-write stimulus and a watchdog
// ==================================================

`timescale 1ns/10ps

module tb;

  localparam int FIFO_DEPTH = 4;
  localparam int CLK_PERIOD = 100;
  // Whole sequence takes about 150 cycles
  localparam int WATCHDOG_CYCLES = 2000;

  logic                   clk;
  logic                   arst_n;
  logic                   strap;
  logic                   jtag_tck;
  logic                   jtag_tms;
  logic                   jtag_tdi;
  logic                   spi_sck;
  logic                   spi_csb;
  logic                   spi_mosi;
  logic                   pad_tdo_miso;
  logic                   pad_clk;
  logic                   pad_din;
  logic                   pad_sel;
  logic                   jtag_tdo;
  logic                   spi_miso;
  logic                   ram_req;
  logic                   ram_write;
  msg_mon_pkg::ram_addr_t ram_addr;
  msg_mon_pkg::ram_data_t ram_wdata;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  msg_mon_pkg::apb_addr_t paddr;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   pready;
  logic                   pslverr;
  integer                 seed = 32'h2e6b_c3bc;
  msg_mon_pkg::ram_addr_t msg_addr;
  msg_mon_pkg::ram_addr_t other_addr;

  msg_mon_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) uut (
    .clk_i              (clk),
    .arst_n_i           (arst_n),
    .strap_jtag_spi_n_i (strap),
    .jtag_tck_i         (jtag_tck),
    .jtag_tms_i         (jtag_tms),
    .jtag_tdi_i         (jtag_tdi),
    .spi_sck_i          (spi_sck),
    .spi_csb_i          (spi_csb),
    .spi_mosi_i         (spi_mosi),
    .pad_tdo_miso_i     (pad_tdo_miso),
    .pad_clk_o          (pad_clk),
    .pad_din_o          (pad_din),
    .pad_sel_o          (pad_sel),
    .jtag_tdo_o         (jtag_tdo),
    .spi_miso_o         (spi_miso),
    .ram_req_i          (ram_req),
    .ram_write_i        (ram_write),
    .ram_addr_i         (ram_addr),
    .ram_wdata_i        (ram_wdata),
    .psel_i             (psel),
    .penable_i          (penable),
    .pwrite_i           (pwrite),
    .paddr_i            (paddr),
    .pwdata_i           (pwdata),
    .prdata_o           (prdata),
    .pready_o           (pready),
    .pslverr_o          (pslverr)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Pad inputs toggle randomly all the time
  always @(posedge clk) begin
    {jtag_tck, jtag_tms, jtag_tdi, spi_sck, spi_csb, spi_mosi, pad_tdo_miso} <=
      7'($random(seed));
  end

  task automatic apply_reset(input logic strap_val);
    @(posedge clk);
    arst_n <= 1'b0;
    strap  <= strap_val;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    // Strap is taken on this edge
    @(posedge clk);
  endtask

  task automatic apb_transfer(input logic wr, input msg_mon_pkg::apb_addr_t addr,
                              input logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    while (!pready) begin
      @(posedge clk);
    end
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input msg_mon_pkg::apb_addr_t addr);
    apb_transfer(1'b0, addr, 32'd0);
  endtask

  task automatic apb_write(input msg_mon_pkg::apb_addr_t addr, input logic [31:0] data);
    apb_transfer(1'b1, addr, data);
  endtask

  task automatic ram_cycle(input logic req, input logic wr,
                           input msg_mon_pkg::ram_addr_t addr,
                           input msg_mon_pkg::ram_data_t data);
    @(posedge clk);
    ram_req   <= req;
    ram_write <= wr;
    ram_addr  <= addr;
    ram_wdata <= data;
  endtask

  // Back-to-back message writes, then the two-cycle snoop latency
  task automatic push_messages(input int n);
    for (int i = 0; i < n; i++) begin
      ram_cycle(1'b1, 1'b1, msg_addr, $random(seed));
    end
    ram_cycle(1'b0, 1'b0, '0, '0);
    repeat (2) @(posedge clk);
  endtask

  initial begin
    wait (uut.u_props.fail_count != 0);
    $display("SIMULATION FAILED");
    $fatal(1, "an assertion on the DUT failed");
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout, the test did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    strap        = 1'b1;
    jtag_tck     = 1'b0;
    jtag_tms     = 1'b0;
    jtag_tdi     = 1'b0;
    spi_sck      = 1'b0;
    spi_csb      = 1'b1;
    spi_mosi     = 1'b0;
    pad_tdo_miso = 1'b0;
    ram_req      = 1'b0;
    ram_write    = 1'b0;
    ram_addr     = '0;
    ram_wdata    = '0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = 32'd0;

    // JTAG strap first
    apply_reset(1'b1);
    apb_read(msg_mon_pkg::REG_STATUS);
    msg_addr = $random(seed);
    apb_write(msg_mon_pkg::REG_MSG_ADDR, msg_addr);
    apb_read(msg_mon_pkg::REG_MSG_ADDR);

    // Near misses that must not be captured
    for (int i = 0; i < 6; i++) begin
      other_addr = $random(seed);
      if (other_addr == msg_addr) begin
        other_addr = ~other_addr;
      end
      ram_cycle(1'b1, 1'b1, other_addr, $random(seed));
      ram_cycle(1'b1, 1'b0, msg_addr, $random(seed));
      ram_cycle(1'b0, 1'b1, msg_addr, $random(seed));
    end
    push_messages(3);
    apb_read(msg_mon_pkg::REG_STATUS);
    // Last read finds the FIFO empty
    repeat (4) apb_read(msg_mon_pkg::REG_DATA);
    apb_read(8'h0c);
    apb_write(8'h10, $random(seed));

    // One more hit than the FIFO holds
    push_messages(5);
    apb_read(msg_mon_pkg::REG_STATUS);
    apb_write(msg_mon_pkg::REG_STATUS, 32'h0000_0100);
    apb_read(msg_mon_pkg::REG_STATUS);
    repeat (5) apb_read(msg_mon_pkg::REG_DATA);

    // Pops overlapping with pushes
    push_messages(2);
    fork
      repeat (3) apb_read(msg_mon_pkg::REG_DATA);
      push_messages(6);
    join
    apb_read(msg_mon_pkg::REG_STATUS);

    // SPI strap on a fresh reset
    apply_reset(1'b0);
    apb_read(msg_mon_pkg::REG_STATUS);
    repeat (20) @(posedge clk);

    if (uut.u_props.fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
rtl/msg_mon_pkg.sv
rtl/ram_snoop_if.sv
rtl/pad_strap_mux.sv
rtl/write_snoop.sv
rtl/msg_fifo.sv
rtl/msg_apb_regs.sv
rtl/msg_mon_top.sv
tests/msg_mon_props.sv
tests/tb.sv

// File: Bender.yml
package:
  name: msg_mon

sources:
  - files:
      - rtl/msg_mon_pkg.sv
      - rtl/ram_snoop_if.sv
      - rtl/pad_strap_mux.sv
      - rtl/write_snoop.sv
      - rtl/msg_fifo.sv
      - rtl/msg_apb_regs.sv
      - rtl/msg_mon_top.sv
  - target: test
    files:
      - tests/msg_mon_props.sv
      - tests/tb.sv
